// File: hdl/fir_pkg.sv
package fir_pkg;

    localparam int sample_w  = 9;   // signed input sample
    localparam int coeff_w   = 9;   // signed coefficient
    localparam int taps      = 73;
    localparam int half_taps = 37;  // folded, index 36 is the centre tap
    localparam int acc_w     = 25;  // 19 bit product plus 6 bits of growth over 37 terms
    localparam int ch_w      = 4;   // up to 16 channels

    // low-pass response, first half plus centre
    localparam logic signed [coeff_w-1:0] coeff_rom [half_taps] = '{
        9'sd0,    -9'sd1,   -9'sd1,   -9'sd2,   -9'sd3,   -9'sd3,   -9'sd4,   -9'sd4,
        -9'sd3,   -9'sd1,   9'sd1,    9'sd3,    9'sd7,    9'sd10,   9'sd12,   9'sd13,
        9'sd12,   9'sd9,    9'sd3,    -9'sd5,   -9'sd14,  -9'sd24,  -9'sd33,  -9'sd40,
        -9'sd43,  -9'sd39,  -9'sd29,  -9'sd12,  9'sd13,   9'sd44,   9'sd80,   9'sd119,
        9'sd157,  9'sd192,  9'sd222,  9'sd243,  9'sd255
    };

    typedef struct packed {
        logic [ch_w-1:0]            ch;      // channel tag
        logic signed [sample_w-1:0] sample;
    } in_word_t;

    typedef struct packed {
        logic [ch_w-1:0]         ch;
        logic signed [acc_w-1:0] value;  // full precision filter output
    } out_word_t;

    typedef enum logic [1:0] {
        st_idle,
        st_mac,      // one folded tap per cycle
        st_release,  // drain product register, latch result
        st_hold      // result waiting for the collector
    } fir_state_t;

    // four-phase req/ack sequencing, shared by splitter and collector
    typedef enum logic [1:0] {
        ln_idle,
        ln_ack,
        ln_wait_drop,
        ln_req
    } link_state_t;

endpackage

// File: hdl/sample_splitter.sv
`timescale 1ns/10ps

module sample_splitter #(
    parameter int num_channels = 2
) (
    input  logic                                           clk,
    input  logic                                           rst,
    input  fir_pkg::in_word_t                              in_word,
    input  logic                                           in_req,
    output logic                                           in_ack,
    input  logic [num_channels-1:0]                        ready,
    output logic [num_channels-1:0][fir_pkg::sample_w-1:0] samples,
    output logic                                           load
);

    fir_pkg::link_state_t     state;
    logic [fir_pkg::ch_w-1:0] exp_ch;     // tag expected on the next word
    logic                     last_ch;
    logic                     all_ready;

    assign last_ch   = exp_ch == fir_pkg::ch_w'(num_channels - 1);
    assign all_ready = &ready;            // every channel back in idle

    // slot write as soon as the word is seen
    always_ff @(posedge clk) begin
        if (state == fir_pkg::ln_idle && in_req) begin
            for (int i = 0; i < num_channels; i++) begin
                if (exp_ch == fir_pkg::ch_w'(i)) begin
                    samples[i] <= in_word.sample;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= fir_pkg::ln_idle;
            exp_ch <= '0;
            in_ack <= 1'b0;
            load   <= 1'b0;
        end else begin
            load <= 1'b0;                 // strobe, one cycle only
            case (state)
                fir_pkg::ln_idle: begin
                    if (in_req) begin
                        if (!last_ch || all_ready) begin
                            in_ack <= 1'b1;
                            load   <= last_ch;  // frame complete, start all filters
                            state  <= fir_pkg::ln_wait_drop;
                        end else begin
                            state <= fir_pkg::ln_ack;  // back-pressure, channels busy
                        end
                    end
                end
                fir_pkg::ln_ack: begin
                    // last word parked here until the bank drains
                    if (all_ready) begin
                        in_ack <= 1'b1;
                        load   <= 1'b1;
                        state  <= fir_pkg::ln_wait_drop;
                    end
                end
                fir_pkg::ln_wait_drop: begin
                    if (!in_req) begin
                        in_ack <= 1'b0;
                        exp_ch <= last_ch ? '0 : exp_ch + 1'b1;  // wrap per frame
                        state  <= fir_pkg::ln_idle;
                    end
                end
                default: state <= fir_pkg::ln_idle;
            endcase
        end
    end

    // source walks the tags 0..n-1 in order
    a_tag_order: assert property (@(posedge clk) disable iff (rst)
        in_req |-> in_word.ch == exp_ch);

    a_word_stable: assert property (@(posedge clk) disable iff (rst)
        in_req |=> !in_req || $stable(in_word));

endmodule

// File: hdl/fir_channel.sv
`timescale 1ns/10ps

module fir_channel (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                load,
    input  logic signed [fir_pkg::sample_w-1:0] din,
    output logic                                ready,
    output logic signed [fir_pkg::acc_w-1:0]    result,
    output logic                                done,
    input  logic                                taken
);

    localparam int k_w    = $clog2(fir_pkg::half_taps);  // forward index, 0..36
    localparam int idx_w  = $clog2(fir_pkg::taps);       // mirror index, 72..36
    localparam int pair_w = fir_pkg::sample_w + 1;
    localparam int prod_w = pair_w + fir_pkg::coeff_w;

    logic signed [fir_pkg::sample_w-1:0] chain [fir_pkg::taps];  // x[n] at 0, x[n-72] at 72
    fir_pkg::fir_state_t                 state;
    logic [k_w-1:0]                      k;
    logic [idx_w-1:0]                    m;
    logic                                centre;
    logic signed [fir_pkg::sample_w-1:0] fwd;
    logic signed [fir_pkg::sample_w-1:0] rev_sel;
    logic signed [pair_w-1:0]            pair;
    logic signed [prod_w-1:0]            prod;     // pipeline reg ahead of acc
    logic signed [fir_pkg::acc_w-1:0]    acc;

    assign ready  = state == fir_pkg::st_idle;
    assign centre = k == k_w'(fir_pkg::half_taps - 1);

    // fold the symmetric pair, centre tap counted once
    assign fwd     = chain[idx_w'(k)];
    assign rev_sel = centre ? '0 : chain[m];
    assign pair    = fwd + rev_sel;

    // delay chain, one shift per frame
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < fir_pkg::taps; i++) begin
                chain[i] <= '0;
            end
        end else if (load) begin
            chain[0] <= din;
            for (int i = 1; i < fir_pkg::taps; i++) begin
                chain[i] <= chain[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= fir_pkg::st_idle;
            k     <= '0;
            m     <= '0;
            prod  <= '0;
            acc   <= '0;
            done  <= 1'b0;
        end else begin
            case (state)
                fir_pkg::st_idle: begin
                    if (load) begin
                        k     <= '0;
                        m     <= idx_w'(fir_pkg::taps - 1);
                        prod  <= '0;   // first mac cycle adds nothing
                        acc   <= '0;
                        state <= fir_pkg::st_mac;
                    end
                end
                fir_pkg::st_mac: begin
                    prod <= pair * fir_pkg::coeff_rom[k];
                    acc  <= acc + prod;  // one tap behind the multiplier
                    if (centre) begin
                        state <= fir_pkg::st_release;
                    end else begin
                        k <= k + 1'b1;
                        m <= m - 1'b1;
                    end
                end
                fir_pkg::st_release: begin
                    done  <= 1'b1;
                    state <= fir_pkg::st_hold;
                end
                fir_pkg::st_hold: begin
                    // parked until the collector has sent the word
                    if (taken) begin
                        done  <= 1'b0;
                        state <= fir_pkg::st_idle;
                    end
                end
                default: state <= fir_pkg::st_idle;
            endcase
        end
    end

    // last product folded in on the drain cycle
    always_ff @(posedge clk) begin
        if (state == fir_pkg::st_release) begin
            result <= acc + prod;
        end
    end

    // splitter must honour ready before strobing
    a_load_idle: assert property (@(posedge clk) disable iff (rst)
        load |-> state == fir_pkg::st_idle);

endmodule

// File: hdl/frame_collector.sv
`timescale 1ns/10ps

module frame_collector #(
    parameter int num_channels = 2
) (
    input  logic                                        clk,
    input  logic                                        rst,
    input  logic [num_channels-1:0][fir_pkg::acc_w-1:0] results,
    input  logic [num_channels-1:0]                     done,
    output logic [num_channels-1:0]                     taken,
    output fir_pkg::out_word_t                          out_word,
    output logic                                        out_req,
    input  logic                                        out_ack
);

    fir_pkg::link_state_t             state;
    logic [fir_pkg::ch_w-1:0]         idx;      // channel currently on the link
    logic                             last_ch;
    logic                             all_done;
    logic                             launch;   // new word goes out next cycle
    logic [fir_pkg::ch_w-1:0]         sel_ch;
    logic signed [fir_pkg::acc_w-1:0] sel_val;

    assign last_ch  = idx == fir_pkg::ch_w'(num_channels - 1);
    assign all_done = &done && !(|taken);  // taken in flight, done not cleared yet

    assign launch = (state == fir_pkg::ln_idle) ? all_done :
                    (state == fir_pkg::ln_wait_drop && !out_ack && !last_ch);

    always_comb begin
        sel_ch  = (state == fir_pkg::ln_idle) ? '0 : idx + 1'b1;
        sel_val = '0;
        for (int i = 0; i < num_channels; i++) begin
            if (sel_ch == fir_pkg::ch_w'(i)) begin
                sel_val = results[i];
            end
        end
    end

    // word loaded together with the req rise
    always_ff @(posedge clk) begin
        if (launch) begin
            out_word.ch    <= sel_ch;
            out_word.value <= sel_val;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= fir_pkg::ln_idle;
            idx     <= '0;
            out_req <= 1'b0;
            taken   <= '0;
        end else begin
            taken <= '0;
            case (state)
                fir_pkg::ln_idle: begin
                    if (launch) begin
                        idx     <= sel_ch;
                        out_req <= 1'b1;
                        state   <= fir_pkg::ln_req;
                    end
                end
                fir_pkg::ln_req: begin
                    if (out_ack) begin
                        out_req <= 1'b0;
                        state   <= fir_pkg::ln_wait_drop;
                    end
                end
                fir_pkg::ln_wait_drop: begin
                    if (!out_ack) begin
                        // handshake closed, release this channel
                        for (int i = 0; i < num_channels; i++) begin
                            taken[i] <= idx == fir_pkg::ch_w'(i);
                        end
                        if (last_ch) begin
                            state <= fir_pkg::ln_idle;
                        end else begin
                            idx     <= sel_ch;
                            out_req <= 1'b1;
                            state   <= fir_pkg::ln_req;
                        end
                    end
                end
                default: state <= fir_pkg::ln_idle;
            endcase
        end
    end

    a_word_stable: assert property (@(posedge clk) disable iff (rst)
        out_req |=> !out_req || $stable(out_word));

endmodule

// File: hdl/fir_bank_top.sv
`timescale 1ns/10ps

module fir_bank_top #(
    parameter int num_channels = 2
) (
    input  logic               clk,
    input  logic               rst,
    input  fir_pkg::in_word_t  in_word,
    input  logic               in_req,
    output logic               in_ack,
    output fir_pkg::out_word_t out_word,
    output logic               out_req,
    input  logic               out_ack
);

    logic [num_channels-1:0][fir_pkg::sample_w-1:0] samples;
    logic                                           load;     // common frame strobe
    logic [num_channels-1:0]                        ready;
    logic [num_channels-1:0][fir_pkg::acc_w-1:0]    results;
    logic [num_channels-1:0]                        done;
    logic [num_channels-1:0]                        taken;

    sample_splitter #(
        .num_channels(num_channels)
    ) splitter_i (
        .clk     (clk),
        .rst     (rst),
        .in_word (in_word),
        .in_req  (in_req),
        .in_ack  (in_ack),
        .ready   (ready),
        .samples (samples),
        .load    (load)
    );

    // one mac filter per channel
    for (genvar g = 0; g < num_channels; g++) begin : g_ch
        fir_channel ch_i (
            .clk    (clk),
            .rst    (rst),
            .load   (load),
            .din    (samples[g]),
            .ready  (ready[g]),
            .result (results[g]),
            .done   (done[g]),
            .taken  (taken[g])
        );
    end

    frame_collector #(
        .num_channels(num_channels)
    ) collector_i (
        .clk      (clk),
        .rst      (rst),
        .results  (results),
        .done     (done),
        .taken    (taken),
        .out_word (out_word),
        .out_req  (out_req),
        .out_ack  (out_ack)
    );

endmodule

// File: sim/tb_fir_bank.sv
`timescale 1ns/10ps

module tb_fir_bank;

    localparam int n_ch      = 2;
    localparam int seed      = 99;
    localparam int wait_max  = 5000;   // cycles allowed per handshake wait
    localparam int drain_max = 20000;  // cycles allowed to empty the scoreboard

    logic               clk;
    logic               rst;
    fir_pkg::in_word_t  in_word;
    logic               in_req;
    logic               in_ack;
    fir_pkg::out_word_t out_word;
    logic               out_req;
    logic               out_ack;

    fir_pkg::out_word_t exp_q [$];           // scoreboard, oldest word first
    int                 hist [n_ch][fir_pkg::taps];  // reference delay lines
    int                 ack_delay_max;       // responder back-pressure
    logic               out_req_q;
    string              test_name;

    fir_bank_top #(
        .num_channels(n_ch)
    ) dut_i (
        .clk      (clk),
        .rst      (rst),
        .in_word  (in_word),
        .in_req   (in_req),
        .in_ack   (in_ack),
        .out_word (out_word),
        .out_req  (out_req),
        .out_ack  (out_ack)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 100 MHz
    end

    // direct form of the symmetric filter, x[n] in slot 0
    function automatic logic signed [fir_pkg::acc_w-1:0] fir_ref(input int ch, input int x);
        int acc;
        for (int i = fir_pkg::taps - 1; i > 0; i--) begin
            hist[ch][i] = hist[ch][i-1];
        end
        hist[ch][0] = x;
        acc = 0;
        for (int k = 0; k < fir_pkg::half_taps - 1; k++) begin
            acc += int'(fir_pkg::coeff_rom[k]) * (hist[ch][k] + hist[ch][fir_pkg::taps-1-k]);
        end
        acc += int'(fir_pkg::coeff_rom[fir_pkg::half_taps-1]) * hist[ch][fir_pkg::half_taps-1];
        // exact sum must be representable in the output word
        if (acc != int'(fir_pkg::acc_w'(acc))) begin
            $display("exact filter sum %0d does not fit in %0d bits in test %s",
                     acc, fir_pkg::acc_w, test_name);
            $display("Verification failed");
            $fatal(1, "accumulator too narrow");
        end
        return fir_pkg::acc_w'(acc);
    endfunction

    function automatic void clear_ref();
        for (int c = 0; c < n_ch; c++) begin
            for (int i = 0; i < fir_pkg::taps; i++) begin
                hist[c][i] = 0;
            end
        end
    endfunction

    function automatic int rand_sample();
        return int'($urandom_range(511, 0)) - 256;  // full 9 bit signed range
    endfunction

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s in test %s", what, test_name);
        $display("Verification failed");
        $fatal(1, "handshake timeout");
    endtask

    task automatic check_tag(input string name, input logic [fir_pkg::ch_w-1:0] exp_ch,
                             input logic [fir_pkg::ch_w-1:0] act_ch);
        if (act_ch !== exp_ch) begin
            $display("** Error %s: tag expected %0d actual %0d", name, exp_ch, act_ch);
            $display("Verification failed");
            $fatal(1, "wrong channel tag");
        end
    endtask

    task automatic check_value(input string name, input logic signed [fir_pkg::acc_w-1:0] exp_v,
                               input logic signed [fir_pkg::acc_w-1:0] act_v);
        if (act_v !== exp_v) begin
            $display("** Error %s: value expected %0d actual %0d", name, exp_v, act_v);
            $display("Verification failed");
            $fatal(1, "wrong filter output");
        end
    endtask

    // polls at each rising edge, values seen are the pre-edge ones
    task automatic wait_in_ack(input logic level);
        int n;
        n = 0;
        @(posedge clk);
        while (in_ack !== level) begin
            if (n == wait_max) begin
                report_timeout("in_ack");
            end
            n++;
            @(posedge clk);
        end
    endtask

    // one word per channel, expected results queued up front
    task automatic send_frame(input int s0, input int s1);
        int                 smp [n_ch];
        fir_pkg::in_word_t  w;
        fir_pkg::out_word_t e;
        smp[0] = s0;
        smp[1] = s1;
        for (int c = 0; c < n_ch; c++) begin
            e.ch    = fir_pkg::ch_w'(c);
            e.value = fir_ref(c, smp[c]);
            exp_q.push_back(e);
        end
        for (int c = 0; c < n_ch; c++) begin
            w.ch     = fir_pkg::ch_w'(c);
            w.sample = fir_pkg::sample_w'(smp[c]);
            @(posedge clk);
            in_word <= w;
            in_req  <= 1'b1;
            wait_in_ack(1'b1);  // last word may stall here while the bank is busy
            in_req <= 1'b0;
            wait_in_ack(1'b0);
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 || out_req || out_ack) begin
            if (n == drain_max) begin
                report_timeout("output drain");
            end
            n++;
            @(posedge clk);
        end
    endtask

    // output side slave, ack after a random hold
    initial begin
        int delay;
        int n;
        forever begin
            @(posedge clk);
            if (out_req && !out_ack) begin
                delay = (ack_delay_max == 0) ? 0 : int'($urandom_range(ack_delay_max, 0));
                repeat (delay) @(posedge clk);
                out_ack <= 1'b1;
                n = 0;
                @(posedge clk);
                while (out_req) begin
                    if (n == wait_max) begin
                        report_timeout("out_req drop");
                    end
                    n++;
                    @(posedge clk);
                end
                out_ack <= 1'b0;
            end
        end
    end

    // scoreboard, one pop per out_req rise
    always @(posedge clk) begin
        fir_pkg::out_word_t exp_w;
        out_req_q <= out_req;
        if (!rst && out_req && !out_req_q) begin
            if (exp_q.size() == 0) begin
                $display("output word with tag %0d arrived with nothing expected", out_word.ch);
                $display("Verification failed");
                $fatal(1, "unexpected output");
            end
            exp_w = exp_q.pop_front();
            check_tag(test_name, exp_w.ch, out_word.ch);  // tags 0 then 1
            check_value(test_name, exp_w.value, out_word.value);
        end
    end

    initial begin
        rst           = 1'b1;
        in_req        = 1'b0;
        in_word       = '0;
        out_ack       = 1'b0;
        out_req_q     = 1'b0;
        ack_delay_max = 0;
        test_name     = "reset";
        void'($urandom(seed));
        clear_ref();
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        test_name = "impulse";  // 100 x coefficients, ch 1 silent
        send_frame(100, 0);
        repeat (fir_pkg::taps - 1) send_frame(0, 0);
        wait_drain();

        test_name = "random";
        repeat (300) send_frame(rand_sample(), rand_sample());
        wait_drain();

        test_name = "full_scale";  // largest magnitude sums
        repeat (80) send_frame(-256, -256);
        repeat (80) send_frame(255, 255);
        wait_drain();

        test_name     = "back_pressure";
        ack_delay_max = 60;
        repeat (40) send_frame(rand_sample(), rand_sample());
        wait_drain();
        ack_delay_max = 0;

        // history is nonzero here, reset must wipe it
        test_name = "mid_reset";
        @(posedge clk);
        rst <= 1'b1;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        clear_ref();
        ack_delay_max = 5;
        repeat (60) send_frame(rand_sample(), rand_sample());
        wait_drain();

        $display("Verification passed");
        $finish;
    end

endmodule

// File: build.f
hdl/fir_pkg.sv
hdl/sample_splitter.sv
hdl/fir_channel.sv
hdl/frame_collector.sv
hdl/fir_bank_top.sv
sim/tb_fir_bank.sv

// File: Makefile
# Verilator build and run for the FIR filter bank

VERILATOR ?= verilator
TOP       ?= tb_fir_bank
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status is nonzero when the testbench stops with $fatal
run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
